/* Makefile */
TOP ?= network_tb
SEED ?= 37397
LOG ?= sim.log
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
VERILATOR ?= verilator
FAIL_MSG = Test failed

VFLAGS = --binary --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR) -GSEED=$(SEED)
SOURCES = $(wildcard hw/*.sv hw/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

# a crash or a fail message in the log both count as failure
run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/network_tb.sv */
// self-checking testbench for the spiking tile, sends random timesteps and checks the sink words
`include "network_defines.svh"

module network_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import network_pkg::*;

    parameter int SEED = 37397;
    localparam int TIMEOUT = 200;
    localparam int POT_MAX = (1 << `NET_POT_WIDTH) - 1;

    logic clk;
    logic arstn;
    logic src_valid;
    logic src_ready;
    src_word_t src;
    logic snk_ready;
    logic snk_valid;
    snk_word_t snk;

    int errors;
    int timeouts;
    int words_seen;
    bit rand_ready;
    // persistent potentials of the model, one per output neuron
    int model_pot [`NET_NUM_OUT];
    // words the sink still owes, in arrival order
    int exp_q [$];

    network_top dut_i (
        .clk(clk),
        .arstn(arstn),
        .src_valid(src_valid),
        .src_ready(src_ready),
        .src(src),
        .snk_ready(snk_ready),
        .snk_valid(snk_valid),
        .snk(snk)
    );

    always #2 clk = ~clk;

    // weight rule written out again, independent of the package
    function automatic int expected_weight(input int i, input int j);
        return ((3 * i + 5 * j) % 7) - 3;
    endfunction

    // integrate one timestep and queue the count then fired indices, highest first
    function automatic void step_model(input bit [`NET_NUM_IN-1:0] spikes);
        int acc;
        int fired [$];
        for (int j = 0; j < `NET_NUM_OUT; j++) begin
            acc = model_pot[j];
            for (int i = 0; i < `NET_NUM_IN; i++) begin
                if (spikes[i])
                    acc += expected_weight(i, j);
            end
            if (acc < 0)
                acc = 0;
            if (acc > POT_MAX)
                acc = POT_MAX;
            if (acc >= `NET_THRESHOLD) begin
                fired.push_back(j);
                model_pot[j] = 0;
            end else begin
                model_pot[j] = acc;
            end
        end
        exp_q.push_back(fired.size());
        for (int n = fired.size() - 1; n >= 0; n--)
            exp_q.push_back(fired[n]);
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
            errors++;
        end
    endtask

    // entered 1 ns after an edge, leaves 1 ns after the transfer edge
    task automatic send_word(input int w);
        int waited;
        waited = 0;
        src_valid = 1'b1;
        src = src_word_t'(w);
        while (!src_ready && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!src_ready) begin
            $display("ERROR: source never became ready for word %0d", w);
            timeouts++;
        end
        @(posedge clk);
        #1;
        src_valid = 1'b0;
    endtask

    task automatic send_timestep(input bit [`NET_NUM_IN-1:0] spikes);
        int idx [$];
        int pick;
        int tmp;
        for (int i = 0; i < `NET_NUM_IN; i++) begin
            if (spikes[i])
                idx.push_back(i);
        end
        // indices go out in a random order
        for (int n = idx.size() - 1; n > 0; n--) begin
            pick = $urandom_range(n, 0);
            tmp = idx[n];
            idx[n] = idx[pick];
            idx[pick] = tmp;
        end
        step_model(spikes);
        send_word(idx.size());
        foreach (idx[n]) begin
            // occasional idle cycle with valid low
            if ($urandom_range(3, 0) == 0) begin
                @(posedge clk);
                #1;
            end
            send_word(idx[n]);
        end
    endtask

    task automatic run_random(input int count);
        bit [`NET_NUM_IN-1:0] spikes;
        repeat (count) begin
            // mix sparse and dense timesteps
            if ($urandom_range(1, 0) == 1)
                spikes = `NET_NUM_IN'($urandom & $urandom);
            else
                spikes = `NET_NUM_IN'($urandom);
            send_timestep(spikes);
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT * 20) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("ERROR: %0d expected words never came out of the sink", exp_q.size());
            timeouts++;
            exp_q.delete();
        end
    endtask

    // model is cleared together with the DUT
    task automatic apply_reset();
        arstn = 1'b0;
        src_valid = 1'b0;
        foreach (model_pot[j])
            model_pot[j] = 0;
        repeat (4) begin
            @(negedge clk);
            check_value(32'(snk_valid), 0, "snk_valid during reset");
            check_value(32'(src_ready), 1, "src_ready during reset");
        end
        @(posedge clk);
        #1;
        arstn = 1'b1;
        @(negedge clk);
        check_value(32'(snk_valid), 0, "snk_valid after reset");
        check_value(32'(src_ready), 1, "src_ready after reset");
        @(posedge clk);
        #1;
    endtask

    // host side of the sink, random stalls only in the back-pressure phase
    always @(posedge clk) begin
        #1;
        snk_ready = rand_ready ? ($urandom_range(3, 0) != 0) : 1'b1;
    end

    // inputs settle 1 ns after the edge, so the negedge sees the coming transfer
    always @(negedge clk) begin
        if (arstn && snk_valid && snk_ready) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: sink sent word %0d when no word was expected", snk);
                errors++;
            end else begin
                check_value(32'(snk), exp_q.pop_front(), "sink word");
            end
            words_seen++;
        end
    end

    initial begin
        clk = 1'b0;
        arstn = 1'b1;
        src_valid = 1'b0;
        src = '0;
        snk_ready = 1'b0;
        errors = 0;
        timeouts = 0;
        words_seen = 0;
        rand_ready = 1'b0;
        void'($urandom(SEED));
        #1;
        apply_reset();

        // empty timestep answers with a zero count
        send_timestep('0);
        // input 0 alone lifts neuron 4 by 3, nothing fires yet
        send_timestep(`NET_NUM_IN'(1));
        wait_drained();
        check_value(model_pot[4], 3, "neuron 4 potential after one step");
        // same spike again reaches the threshold on neuron 4
        send_timestep(`NET_NUM_IN'(1));
        wait_drained();
        check_value(model_pot[4], 0, "neuron 4 potential after firing");

        run_random(60);
        rand_ready = 1'b1;
        run_random(60);
        wait_drained();

        // second reset must clear the potentials, so input 0 fires nothing again
        apply_reset();
        send_timestep(`NET_NUM_IN'(1));
        run_random(40);
        wait_drained();

        $display("errors %0d, timeouts %0d, words checked %0d", errors, timeouts, words_seen);
        if (errors == 0 && timeouts == 0 && words_seen > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+hw
hw/network_pkg.sv
hw/network_source.sv
hw/network_core.sv
hw/network_sink.sv
hw/network_top.sv
bench/network_tb.sv

/* hw/network_core.sv */
// one layer of integrate-and-fire neurons whose potentials carry over between timesteps
`include "network_defines.svh"

module network_core (
    input logic clk,
    input logic arstn,
    // spike beat from the source
    input logic spk_valid,
    output logic spk_ready,
    input network_pkg::spike_beat_t spk,
    // fired vector to the sink
    output logic net_valid,
    input logic net_ready,
    output network_pkg::out_fires_t net_out
);
    import network_pkg::*;

    localparam int POT_MAX = (1 << `NET_POT_WIDTH) - 1;

    potential_t pot [`NET_NUM_OUT];
    potential_t pot_next [`NET_NUM_OUT];
    out_fires_t fire_next;
    logic spk_fire;

    // the output register may be refilled on the same edge it is drained
    assign spk_ready = !net_valid || net_ready;
    assign spk_fire = spk_valid && spk_ready;

    // integrate this timestep for every output neuron
    always_comb begin
        int acc;
        for (int j = 0; j < `NET_NUM_OUT; j++) begin
            acc = int'(pot[j]);
            for (int i = 0; i < `NET_NUM_IN; i++) begin
                if (spk.spikes[i])
                    acc = acc + int'(synapse_weight(i, j));
            end
            // saturate at both ends of the potential range
            if (acc < 0)
                acc = 0;
            else if (acc > POT_MAX)
                acc = POT_MAX;
            fire_next[j] = (acc >= `NET_THRESHOLD);
            // fired neuron starts over from rest
            pot_next[j] = fire_next[j] ? '0 : potential_t'(acc);
        end
    end

    // potentials persist across timesteps, only reset clears them
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            foreach (pot[j])
                pot[j] <= '0;
        end else if (spk_fire) begin
            foreach (pot[j])
                pot[j] <= pot_next[j];
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            net_valid <= 1'b0;
        end else if (spk_fire) begin
            net_valid <= 1'b1;
        end else if (net_ready) begin
            net_valid <= 1'b0;
        end
    end

    // fired vector waits here until the sink takes it
    always_ff @(posedge clk) begin
        if (spk_fire)
            net_out <= fire_next;
    end

    // a held result must not change before the sink accepts it
    a_net_hold: assert property (@(posedge clk) disable iff (!arstn)
        (net_valid && !net_ready) |=> net_valid && $stable(net_out));

    // source flags an empty timestep only when no input spiked
    a_empty_hint: assert property (@(posedge clk) disable iff (!arstn)
        (spk_valid && spk.empty) |-> (spk.spikes == '0));

endmodule

/* hw/network_defines.svh */
// network size and neuron threshold macros, included by the package and by RTL that sizes logic
`ifndef NETWORK_DEFINES_SVH
`define NETWORK_DEFINES_SVH

// input neurons, one bit each in the spike vector
`define NET_NUM_IN 8

// output neurons of the single integrate-and-fire layer
`define NET_NUM_OUT 8

// a neuron fires once its potential reaches this value
`define NET_THRESHOLD 6

// bits of one membrane potential, unsigned and saturating
`define NET_POT_WIDTH 6

`endif

/* hw/network_pkg.sv */
// shared types and the fixed synapse weight rule, imported by every block of the tile
`include "network_defines.svh"

package network_pkg;

    // host side word, holds an input index or a count up to NET_NUM_IN
    typedef logic [$clog2(`NET_NUM_IN + 1)-1:0] src_word_t;

    // host side word, holds an output index or a count up to NET_NUM_OUT
    typedef logic [$clog2(`NET_NUM_OUT + 1)-1:0] snk_word_t;

    // one bit per input neuron, set when it spiked this timestep
    typedef logic [`NET_NUM_IN-1:0] in_spikes_t;

    // one bit per output neuron, set when it fired this timestep
    typedef logic [`NET_NUM_OUT-1:0] out_fires_t;

    typedef logic [`NET_POT_WIDTH-1:0] potential_t;
    typedef logic signed [3:0] weight_t;

    // one timestep handed from the source to the core
    typedef struct packed {
        logic empty;
        in_spikes_t spikes;
    } spike_beat_t;

    // weight from input i to output j, always within -3..+3
    function automatic weight_t synapse_weight(input int i, input int j);
        return weight_t'(((3 * i + 5 * j) % 7) - 3);
    endfunction

endpackage

/* hw/network_sink.sv */
// captures a fired vector and streams it out as a count then the fired indices, highest first
`include "network_defines.svh"

module network_sink (
    input logic clk,
    input logic arstn,
    // fired vector from the core
    input logic net_valid,
    output logic net_ready,
    input network_pkg::out_fires_t net_out,
    // host stream
    input logic snk_ready,
    output logic snk_valid,
    output network_pkg::snk_word_t snk
);
    import network_pkg::*;

    localparam int CNT_W = $clog2(`NET_NUM_OUT + 2);
    localparam int IDX_W = $clog2(`NET_NUM_OUT);

    out_fires_t fires;
    logic [CNT_W-1:0] pop_cnt;
    logic [CNT_W-1:0] snk_ptr;
    logic [CNT_W-1:0] scan_idx;
    logic scan_fire;
    logic push;
    logic net_fire;
    logic snk_fire;

    // indices pushed in ascending order, count pushed last on top
    snk_word_t stack [`NET_NUM_OUT + 1];

    // scanning and draining never overlap with taking a new vector
    assign net_ready = (pop_cnt == '0) && (snk_ptr == '0);
    assign snk_valid = (pop_cnt == '0) && (snk_ptr != '0);
    assign net_fire = net_valid && net_ready;
    assign snk_fire = snk_valid && snk_ready;

    // pop counter runs down, so scan position runs up from index 0
    assign scan_idx = CNT_W'(`NET_NUM_OUT + 1) - pop_cnt;
    assign scan_fire = (pop_cnt > CNT_W'(1)) && fires[scan_idx[IDX_W-1:0]];
    // last scan step always pushes the count
    assign push = (pop_cnt == CNT_W'(1)) || scan_fire;

    assign snk = stack[snk_ptr - 1'b1];

    always_ff @(posedge clk) begin
        if (net_fire)
            fires <= net_out;
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            pop_cnt <= '0;
        end else if (net_fire) begin
            pop_cnt <= CNT_W'(`NET_NUM_OUT + 1);
        end else if (pop_cnt != '0) begin
            pop_cnt <= pop_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_cnt == CNT_W'(1)) begin
            // entries so far equal the number of fired outputs
            stack[snk_ptr] <= snk_word_t'(snk_ptr);
        end else if (scan_fire) begin
            stack[snk_ptr] <= snk_word_t'(scan_idx);
        end
    end

    // stack pointer, push while scanning and pop while draining
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            snk_ptr <= '0;
        end else if (push) begin
            snk_ptr <= snk_ptr + 1'b1;
        end else if (snk_fire) begin
            snk_ptr <= snk_ptr - 1'b1;
        end
    end

    // a word offered to the host holds until it is taken
    a_snk_hold: assert property (@(posedge clk) disable iff (!arstn)
        (snk_valid && !snk_ready) |=> snk_valid && $stable(snk));

    // scan pushed exactly one entry per fired output before the count goes on top
    a_count_match: assert property (@(posedge clk) disable iff (!arstn)
        (pop_cnt == CNT_W'(1)) |-> (int'(snk_ptr) == $countones(fires)));

endmodule

/* hw/network_source.sv */
// turns the host count-then-indices word stream into one spike vector per timestep
`include "network_defines.svh"

module network_source (
    input logic clk,
    input logic arstn,
    // host stream
    input logic src_valid,
    output logic src_ready,
    input network_pkg::src_word_t src,
    // spike beat to the core
    output logic spk_valid,
    input logic spk_ready,
    output network_pkg::spike_beat_t spk
);
    import network_pkg::*;

    localparam int IDX_W = $clog2(`NET_NUM_IN);

    typedef enum logic [1:0] {IDLE, COLLECT, PRESENT} state_t;

    state_t state;
    src_word_t remain;
    in_spikes_t spikes;
    logic empty;
    logic src_fire;

    // host words are only taken while no beat waits for the core
    assign src_ready = (state != PRESENT);
    assign src_fire = src_valid && src_ready;
    assign spk_valid = (state == PRESENT);
    assign spk.empty = empty;
    assign spk.spikes = spikes;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            state <= IDLE;
            remain <= '0;
        end else begin
            case (state)
                IDLE: if (src_fire) begin
                    // first word is the count, a zero count closes the timestep at once
                    remain <= src;
                    state <= (src == '0) ? PRESENT : COLLECT;
                end
                COLLECT: if (src_fire) begin
                    remain <= remain - 1'b1;
                    if (remain == src_word_t'(1))
                        state <= PRESENT;
                end
                PRESENT: if (spk_ready) begin
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // spike vector is cleared by the count word and built up by the indices
    always_ff @(posedge clk) begin
        if (src_fire && state == IDLE) begin
            spikes <= '0;
            empty <= (src == '0);
        end else if (src_fire && state == COLLECT) begin
            spikes[src[IDX_W-1:0]] <= 1'b1;
        end
    end

    // host promise: every index is in range and appears once per timestep
    a_index_legal: assert property (@(posedge clk) disable iff (!arstn)
        (state == COLLECT && src_valid) |-> (int'(src) < `NET_NUM_IN) && !spikes[src[IDX_W-1:0]]);

endmodule

/* hw/network_top.sv */
// inference tile top, chains the spike source, the neuron layer and the fired-index sink
module network_top (
    input logic clk,
    input logic arstn,
    // host to tile
    input logic src_valid,
    output logic src_ready,
    input network_pkg::src_word_t src,
    // tile to host
    input logic snk_ready,
    output logic snk_valid,
    output network_pkg::snk_word_t snk
);
    import network_pkg::*;

    logic spk_valid;
    logic spk_ready;
    spike_beat_t spk;
    logic net_valid;
    logic net_ready;
    out_fires_t net_out;

    // word stream into a spike vector
    network_source source_i (
        .clk(clk),
        .arstn(arstn),
        .src_valid(src_valid),
        .src_ready(src_ready),
        .src(src),
        .spk_valid(spk_valid),
        .spk_ready(spk_ready),
        .spk(spk)
    );

    network_core core_i (
        .clk(clk),
        .arstn(arstn),
        .spk_valid(spk_valid),
        .spk_ready(spk_ready),
        .spk(spk),
        .net_valid(net_valid),
        .net_ready(net_ready),
        .net_out(net_out)
    );

    // fired vector back into words
    network_sink sink_i (
        .clk(clk),
        .arstn(arstn),
        .net_valid(net_valid),
        .net_ready(net_ready),
        .net_out(net_out),
        .snk_ready(snk_ready),
        .snk_valid(snk_valid),
        .snk(snk)
    );

endmodule
